//--- Makefile
# Verilator build for the decode stage and its testbench

TOP ?= thorDecoderTb
FILELIST ?= thorDecoder.f
LOG ?= sim.log
OBJ_DIR ?= obj_dir
VERILATOR ?= verilator
VERILATOR_FLAGS ?= --timing
PASS_TEXT ?= All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/thorCtrlDecode.sv
`timescale 1ns/10ps
`default_nettype none

module thorCtrlDecode
	import thorIsaPkg::*, thorDecodePkg::*;
(
	input  Instruction ir,
	output RegIdx      Ra,
	output RegIdx      Rb,
	output RegIdx      Rc,
	output RegIdx      Rt,
	output logic       rfwr,
	output logic       hasImm,
	output logic       ld,
	output logic       st,
	output logic       jxx,
	output logic       jmp,
	output logic       multiCycle,
	output MemSize     memsz
);

	// ====================
	// Register fields
	// ====================
	always_comb
	begin
		Ra = ir.r3.Ra;
		Rb = ir.r3.Rb;

		// Stores carry their data register in the Rt slot
		case (ir.any.opcode)
			STB, STW, STO:
				Rc = ir.st.Rs;
			default:
				Rc = ir.r3.Rc;
		endcase

		case (ir.any.opcode)
			STB, STW, STO, JEQ, JNE, JMP:
				Rt = REG_ZERO;
			default:
				Rt = ir.r3.Rt;
		endcase
	end

	// ====================
	// Class flags
	// ====================
	always_comb
	begin
		case (ir.any.opcode)
			R3, ADDI, ANDI, ORI, ADDIL, LDB, LDW, LDO:
				rfwr = 1'b1;
			default:
				rfwr = 1'b0;
		endcase

		case (ir.any.opcode)
			ADDI, ANDI, ORI, ADDIL, LDB, LDW, LDO, STB, STW, STO:
				hasImm = 1'b1;
			default:
				hasImm = 1'b0;
		endcase

		case (ir.any.opcode)
			LDB, LDW, LDO:
				ld = 1'b1;
			default:
				ld = 1'b0;
		endcase

		case (ir.any.opcode)
			STB, STW, STO:
				st = 1'b1;
			default:
				st = 1'b0;
		endcase

		// Memory ops need the load/store unit for more than one cycle
		multiCycle = ld | st;

		jxx = (ir.any.opcode == JEQ) || (ir.any.opcode == JNE);
		jmp = (ir.any.opcode == JMP);
	end

	// Access size
	always_comb
	begin
		case (ir.any.opcode)
			LDB, STB:
				memsz = byt;
			LDW, STW:
				memsz = wyde;
			default:
				memsz = octa;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/thorDecodeMerge.sv
`timescale 1ns/10ps
`default_nettype none

module thorDecodeMerge
	import thorIsaPkg::*, thorDecodePkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   irValid,
	input  RegIdx  Ra,
	input  RegIdx  Rb,
	input  RegIdx  Rc,
	input  RegIdx  Rt,
	input  logic   rfwr,
	input  logic   hasImm,
	input  logic   ld,
	input  logic   st,
	input  MemSize memsz,
	input  logic   jxx,
	input  logic   jmp,
	input  logic   multiCycle,
	input  Value   imm,
	input  logic   xirIsPostfix,
	output logic   decoValid,
	output RegIdx  decoRa,
	output RegIdx  decoRb,
	output RegIdx  decoRc,
	output RegIdx  decoRt,
	output logic   decoRfwr,
	output logic   decoMem,
	output logic   decoLd,
	output logic   decoSt,
	output MemSize decoMemsz,
	output logic   decoBranch,
	output logic   decoJmp,
	output logic   decoMultiCycle,
	output Value   decoImm,
	output logic   decoPostfixUsed
);

	logic rfwrEff;
	logic postfixUsed;

	// Writes to r0 are discarded
	assign rfwrEff = rfwr && (Rt != REG_ZERO);
	// Fetch skips the next word when the postfix was consumed
	assign postfixUsed = xirIsPostfix & hasImm;

	// ====================
	// Output register
	// ====================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			decoValid <= 1'b0;
			decoRa <= '0;
			decoRb <= '0;
			decoRc <= '0;
			decoRt <= '0;
			decoRfwr <= 1'b0;
			decoMem <= 1'b0;
			decoLd <= 1'b0;
			decoSt <= 1'b0;
			decoMemsz <= byt;
			decoBranch <= 1'b0;
			decoJmp <= 1'b0;
			decoMultiCycle <= 1'b0;
			decoImm <= '0;
			decoPostfixUsed <= 1'b0;
		end
		else
		begin
			decoValid <= irValid;
			// Fields hold their last value between strobes
			if (irValid)
			begin
				decoRa <= Ra;
				decoRb <= Rb;
				decoRc <= Rc;
				decoRt <= Rt;
				decoRfwr <= rfwrEff;
				decoMem <= ld | st;
				decoLd <= ld;
				decoSt <= st;
				decoMemsz <= memsz;
				decoBranch <= jxx;
				decoJmp <= jmp;
				decoMultiCycle <= multiCycle;
				decoImm <= imm;
				decoPostfixUsed <= postfixUsed;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/thorDecodePkg.sv
`default_nettype none

package thorDecodePkg;

	// Architectural register number
	typedef logic [5:0] RegIdx;

	// Full machine word
	typedef logic [63:0] Value;

	// Access width named after the ISA size letters
	typedef enum logic [1:0] {
		byt   = 2'd0,
		wyde  = 2'd1,
		tetra = 2'd2,
		octa  = 2'd3
	} MemSize;

endpackage

`default_nettype wire

//--- hw/thorDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module thorDecoder
	import thorIsaPkg::*, thorDecodePkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       irValid,
	input  Instruction ir,
	input  Instruction xir,
	output logic       decoValid,
	output RegIdx      decoRa,
	output RegIdx      decoRb,
	output RegIdx      decoRc,
	output RegIdx      decoRt,
	output logic       decoRfwr,
	output logic       decoMem,
	output logic       decoLd,
	output logic       decoSt,
	output MemSize     decoMemsz,
	output logic       decoBranch,
	output logic       decoJmp,
	output logic       decoMultiCycle,
	output Value       decoImm,
	output logic       decoPostfixUsed
);

	RegIdx  ctrlRa;
	RegIdx  ctrlRb;
	RegIdx  ctrlRc;
	RegIdx  ctrlRt;
	logic   ctrlRfwr;
	logic   ctrlHasImm;
	logic   ctrlLd;
	logic   ctrlSt;
	logic   ctrlJxx;
	logic   ctrlJmp;
	logic   ctrlMultiCycle;
	MemSize ctrlMemsz;
	Value   immVal;
	logic   immXirIsPostfix;

	// Control and immediate decode run in parallel off the same word
	thorCtrlDecode ctrl0 (
		.ir(ir),
		.Ra(ctrlRa),
		.Rb(ctrlRb),
		.Rc(ctrlRc),
		.Rt(ctrlRt),
		.rfwr(ctrlRfwr),
		.hasImm(ctrlHasImm),
		.ld(ctrlLd),
		.st(ctrlSt),
		.jxx(ctrlJxx),
		.jmp(ctrlJmp),
		.multiCycle(ctrlMultiCycle),
		.memsz(ctrlMemsz)
	);

	thorImmGen imm0 (
		.ir(ir),
		.xir(xir),
		.imm(immVal),
		.xirIsPostfix(immXirIsPostfix)
	);

	thorDecodeMerge merge0 (
		.clk(clk),
		.rst(rst),
		.irValid(irValid),
		.Ra(ctrlRa),
		.Rb(ctrlRb),
		.Rc(ctrlRc),
		.Rt(ctrlRt),
		.rfwr(ctrlRfwr),
		.hasImm(ctrlHasImm),
		.ld(ctrlLd),
		.st(ctrlSt),
		.memsz(ctrlMemsz),
		.jxx(ctrlJxx),
		.jmp(ctrlJmp),
		.multiCycle(ctrlMultiCycle),
		.imm(immVal),
		.xirIsPostfix(immXirIsPostfix),
		.decoValid(decoValid),
		.decoRa(decoRa),
		.decoRb(decoRb),
		.decoRc(decoRc),
		.decoRt(decoRt),
		.decoRfwr(decoRfwr),
		.decoMem(decoMem),
		.decoLd(decoLd),
		.decoSt(decoSt),
		.decoMemsz(decoMemsz),
		.decoBranch(decoBranch),
		.decoJmp(decoJmp),
		.decoMultiCycle(decoMultiCycle),
		.decoImm(decoImm),
		.decoPostfixUsed(decoPostfixUsed)
	);

endmodule

`default_nettype wire

//--- hw/thorImmGen.sv
`timescale 1ns/10ps
`default_nettype none

module thorImmGen
	import thorDecodePkg::*;
(
	input  thorIsaPkg::Instruction ir,
	input  thorIsaPkg::Instruction xir,
	output Value                   imm,
	output logic                   xirIsPostfix
);

	logic [7:0] opcode;
	logic       isBranch;
	Value       baseImm;

	assign opcode = ir.any.opcode;
	assign isBranch = (opcode == thorIsaPkg::JEQ) || (opcode == thorIsaPkg::JNE)
		|| (opcode == thorIsaPkg::JMP);
	assign xirIsPostfix = (xir.any.opcode == thorIsaPkg::EXI23);

	// ====================
	// Base immediate
	// ====================
	always_comb
	begin
		case (opcode)
			thorIsaPkg::ADDI:
				baseImm = {{48{ir.ri.imm[15]}}, ir.ri.imm};
			// Ones on the left keep the upper bits under AND
			thorIsaPkg::ANDI:
				baseImm = {{48{1'b1}}, ir.ri.imm};
			thorIsaPkg::ORI:
				baseImm = {48'd0, ir.ri.imm};
			thorIsaPkg::ADDIL:
				baseImm = {{41{ir.ril.imm[22]}}, ir.ril.imm};
			thorIsaPkg::LDB, thorIsaPkg::LDW, thorIsaPkg::LDO:
				baseImm = {{40{ir.ld.disp[23]}}, ir.ld.disp};
			thorIsaPkg::STB, thorIsaPkg::STW, thorIsaPkg::STO:
				baseImm = {{40{ir.st.disp[23]}}, ir.st.disp};
			// Targets count half-words
			thorIsaPkg::JEQ, thorIsaPkg::JNE:
				baseImm = {{42{ir.jxx.tgt[20]}}, ir.jxx.tgt, 1'b0};
			thorIsaPkg::JMP:
				baseImm = {{24{ir.jmp.tgt[38]}}, ir.jmp.tgt, 1'b0};
			default:
				baseImm = '0;
		endcase
	end

	// Postfix replaces everything above bit 22
	always_comb
	begin
		if (xirIsPostfix && !isBranch)
			imm = {{18{xir.pfx.ext[22]}}, xir.pfx.ext, baseImm[22:0]};
		else
			imm = baseImm;
	end

endmodule

`default_nettype wire

//--- hw/thorIsaPkg.sv
`default_nettype none

package thorIsaPkg;

	// ====================
	// Opcodes
	// ====================
	localparam logic [7:0] NOP   = 8'h00;
	localparam logic [7:0] R3    = 8'h03;
	localparam logic [7:0] ADDI  = 8'h04;
	localparam logic [7:0] ANDI  = 8'h08;
	localparam logic [7:0] ORI   = 8'h09;
	localparam logic [7:0] ADDIL = 8'h44;
	localparam logic [7:0] LDB   = 8'h80;
	localparam logic [7:0] LDW   = 8'h82;
	localparam logic [7:0] LDO   = 8'h86;
	localparam logic [7:0] STB   = 8'h90;
	localparam logic [7:0] STW   = 8'h91;
	localparam logic [7:0] STO   = 8'h93;
	localparam logic [7:0] JEQ   = 8'h26;
	localparam logic [7:0] JNE   = 8'h27;
	localparam logic [7:0] JMP   = 8'h20;
	localparam logic [7:0] EXI23 = 8'h52;

	// Register 0 always reads as zero
	localparam logic [5:0] REG_ZERO = 6'd0;

	// ====================
	// Instruction formats
	// ====================
	typedef struct packed {
		logic [38:0] rest;
		logic        vec;
		logic [7:0]  opcode;
	} AnyFmt;

	typedef struct packed {
		logic [7:0] func;
		logic [6:0] pad;
		logic [5:0] Rc;
		logic [5:0] Rb;
		logic [5:0] Ra;
		logic [5:0] Rt;
		logic       vec;
		logic [7:0] opcode;
	} R3Fmt;

	typedef struct packed {
		logic [10:0] pad;
		logic [15:0] imm;
		logic [5:0]  Ra;
		logic [5:0]  Rt;
		logic        vec;
		logic [7:0]  opcode;
	} RiFmt;

	typedef struct packed {
		logic [22:0] imm;
		logic [9:0]  pad;
		logic [5:0]  Rt;
		logic        vec;
		logic [7:0]  opcode;
	} RilFmt;

	typedef struct packed {
		logic [23:0] disp;
		logic [2:0]  pad;
		logic [5:0]  Ra;
		logic [5:0]  Rt;
		logic        vec;
		logic [7:0]  opcode;
	} LdFmt;

	// Store data register sits where a load puts its target
	typedef struct packed {
		logic [23:0] disp;
		logic [2:0]  pad;
		logic [5:0]  Ra;
		logic [5:0]  Rs;
		logic        vec;
		logic [7:0]  opcode;
	} StFmt;

	typedef struct packed {
		logic [20:0] tgt;
		logic [5:0]  Rb;
		logic [5:0]  Ra;
		logic [5:0]  pad;
		logic        vec;
		logic [7:0]  opcode;
	} JxxFmt;

	typedef struct packed {
		logic [38:0] tgt;
		logic        vec;
		logic [7:0]  opcode;
	} JmpFmt;

	typedef struct packed {
		logic [15:0] pad;
		logic [22:0] ext;
		logic        vec;
		logic [7:0]  opcode;
	} PfxFmt;

	typedef union packed {
		AnyFmt any;
		R3Fmt  r3;
		RiFmt  ri;
		RilFmt ril;
		LdFmt  ld;
		StFmt  st;
		JxxFmt jxx;
		JmpFmt jmp;
		PfxFmt pfx;
	} Instruction;

endpackage

`default_nettype wire

//--- thorDecoder.f
hw/thorIsaPkg.sv
hw/thorDecodePkg.sv
hw/thorCtrlDecode.sv
hw/thorImmGen.sv
hw/thorDecodeMerge.sv
hw/thorDecoder.sv
verification/thorDecoderTb.sv

//--- verification/thorDecoderTb.sv
`timescale 1ns/10ps
`default_nettype none

module thorDecoderTb
	import thorIsaPkg::*, thorDecodePkg::*;
();

	logic       clk = 1'b0;
	logic       rst;
	logic       irValid;
	Instruction ir;
	Instruction xir;
	logic       decoValid;
	RegIdx      decoRa;
	RegIdx      decoRb;
	RegIdx      decoRc;
	RegIdx      decoRt;
	logic       decoRfwr;
	logic       decoMem;
	logic       decoLd;
	logic       decoSt;
	MemSize     decoMemsz;
	logic       decoBranch;
	logic       decoJmp;
	logic       decoMultiCycle;
	Value       decoImm;
	logic       decoPostfixUsed;
	integer     seed;

	// Stimulus table with one slot per entry
	string       nameQ[$];
	Instruction  irQ[$];
	Instruction  xirQ[$];
	logic [2:0]  maskQ[$];
	logic [17:0] srcQ[$];
	RegIdx       rtQ[$];
	logic [6:0]  flagQ[$];
	MemSize      sizeQ[$];
	Value        immQ[$];

	thorDecoder dut0 (
		.clk(clk),
		.rst(rst),
		.irValid(irValid),
		.ir(ir),
		.xir(xir),
		.decoValid(decoValid),
		.decoRa(decoRa),
		.decoRb(decoRb),
		.decoRc(decoRc),
		.decoRt(decoRt),
		.decoRfwr(decoRfwr),
		.decoMem(decoMem),
		.decoLd(decoLd),
		.decoSt(decoSt),
		.decoMemsz(decoMemsz),
		.decoBranch(decoBranch),
		.decoJmp(decoJmp),
		.decoMultiCycle(decoMultiCycle),
		.decoImm(decoImm),
		.decoPostfixUsed(decoPostfixUsed)
	);

	always #10 clk = ~clk;

	// ====================
	// Instruction encoders
	// ====================
	function automatic Instruction r3Word(input RegIdx rt, input RegIdx ra, input RegIdx rb,
			input RegIdx rc);
		return {8'h00, 7'd0, rc, rb, ra, rt, 1'b0, R3};
	endfunction

	function automatic Instruction riWord(input logic [7:0] op, input RegIdx rt, input RegIdx ra,
			input logic [15:0] imm);
		return {11'd0, imm, ra, rt, 1'b0, op};
	endfunction

	function automatic Instruction rilWord(input RegIdx rt, input logic [22:0] imm);
		return {imm, 10'd0, rt, 1'b0, ADDIL};
	endfunction

	// Stores put the data register in the Rt slot
	function automatic Instruction memWord(input logic [7:0] op, input RegIdx rt, input RegIdx ra,
			input logic [23:0] disp);
		return {disp, 3'd0, ra, rt, 1'b0, op};
	endfunction

	function automatic Instruction jxxWord(input logic [7:0] op, input RegIdx ra, input RegIdx rb,
			input logic [20:0] tgt);
		return {tgt, rb, ra, 6'd0, 1'b0, op};
	endfunction

	function automatic Instruction jmpWord(input logic [38:0] tgt);
		return {tgt, 1'b0, JMP};
	endfunction

	function automatic Instruction pfxWord(input logic [22:0] ext);
		return {16'd0, ext, 1'b0, EXI23};
	endfunction

	// Mask picks which of Ra, Rb and Rc are compared
	// Flags are {rfwr, mem, ld, st, branch, jmp, postfix}
	task automatic addEntry(input string name, input Instruction irWord, input Instruction xirWord,
			input logic [2:0] mask, input logic [17:0] src, input RegIdx rt,
			input logic [6:0] flags, input MemSize size, input Value imm);
		nameQ.push_back(name);
		irQ.push_back(irWord);
		xirQ.push_back(xirWord);
		maskQ.push_back(mask);
		srcQ.push_back(src);
		rtQ.push_back(rt);
		flagQ.push_back(flags);
		sizeQ.push_back(size);
		immQ.push_back(imm);
	endtask

	task automatic buildTable();
		integer      k;
		logic [31:0] rnd;
		RegIdx       ra;
		RegIdx       rb;
		RegIdx       rc;
		RegIdx       rt;
		// Last R3 entry targets r0 so the write enable must drop
		for (k = 0; k < 3; k++)
		begin
			rnd = $random(seed);
			ra = rnd[5:0];
			rb = rnd[11:6];
			rc = rnd[17:12];
			rt = (k == 2) ? 6'd0 : rnd[23:18];
			addEntry($sformatf("r3_rand%0d", k), r3Word(rt, ra, rb, rc), 48'd0, 3'b111,
				{ra, rb, rc}, rt, {(rt != 6'd0), 6'b000000}, octa, 64'd0);
		end
		addEntry("addi_sext", riWord(ADDI, 6'd5, 6'd6, 16'h8123), 48'd0, 3'b000, 18'd0,
			6'd5, 7'b1000000, octa, 64'hFFFF_FFFF_FFFF_8123);
		addEntry("andi_ones", riWord(ANDI, 6'd7, 6'd2, 16'h00F0), 48'd0, 3'b000, 18'd0,
			6'd7, 7'b1000000, octa, 64'hFFFF_FFFF_FFFF_00F0);
		addEntry("ori_zeros", riWord(ORI, 6'd8, 6'd3, 16'h8421), 48'd0, 3'b000, 18'd0,
			6'd8, 7'b1000000, octa, 64'h0000_0000_0000_8421);
		addEntry("addil_sext", rilWord(6'd9, 23'h40_1234), 48'd0, 3'b000, 18'd0,
			6'd9, 7'b1000000, octa, 64'hFFFF_FFFF_FFC0_1234);
		addEntry("ldb", memWord(LDB, 6'd10, 6'd4, 24'hFF_FF80), 48'd0, 3'b100,
			{6'd4, 12'd0}, 6'd10, 7'b1110000, byt, 64'hFFFF_FFFF_FFFF_FF80);
		addEntry("ldw", memWord(LDW, 6'd11, 6'd5, 24'h00_0100), 48'd0, 3'b100,
			{6'd5, 12'd0}, 6'd11, 7'b1110000, wyde, 64'h0000_0000_0000_0100);
		addEntry("ldo", memWord(LDO, 6'd12, 6'd6, 24'h7F_FFFF), 48'd0, 3'b100,
			{6'd6, 12'd0}, 6'd12, 7'b1110000, octa, 64'h0000_0000_007F_FFFF);
		addEntry("stb", memWord(STB, 6'd13, 6'd7, 24'h80_0000), 48'd0, 3'b101,
			{6'd7, 6'd0, 6'd13}, 6'd0, 7'b0101000, byt, 64'hFFFF_FFFF_FF80_0000);
		addEntry("stw", memWord(STW, 6'd14, 6'd8, 24'h00_0010), 48'd0, 3'b101,
			{6'd8, 6'd0, 6'd14}, 6'd0, 7'b0101000, wyde, 64'h0000_0000_0000_0010);
		addEntry("sto", memWord(STO, 6'd15, 6'd9, 24'hFF_FFFF), 48'd0, 3'b101,
			{6'd9, 6'd0, 6'd15}, 6'd0, 7'b0101000, octa, 64'hFFFF_FFFF_FFFF_FFFF);
		addEntry("jeq_pfx_ignored", jxxWord(JEQ, 6'd1, 6'd2, 21'h10_0000), pfxWord(23'h7F_FFFF),
			3'b110, {6'd1, 6'd2, 6'd0}, 6'd0, 7'b0000100, octa, 64'hFFFF_FFFF_FFE0_0000);
		addEntry("jne", jxxWord(JNE, 6'd3, 6'd4, 21'h00_0123), 48'd0, 3'b110,
			{6'd3, 6'd4, 6'd0}, 6'd0, 7'b0000100, octa, 64'h0000_0000_0000_0246);
		addEntry("jmp_pfx_ignored", jmpWord(39'h40_0000_0001), pfxWord(23'h00_0001), 3'b000,
			18'd0, 6'd0, 7'b0000010, octa, 64'hFFFF_FF80_0000_0002);
		addEntry("addi_pfx", riWord(ADDI, 6'd5, 6'd1, 16'h1234), pfxWord(23'h40_0001), 3'b000,
			18'd0, 6'd5, 7'b1000001, octa, 64'hFFFF_E000_0080_1234);
		addEntry("addi_nopfx", riWord(ADDI, 6'd5, 6'd1, 16'h1234), 48'd0, 3'b000,
			18'd0, 6'd5, 7'b1000000, octa, 64'h0000_0000_0000_1234);
		addEntry("ldo_pfx", memWord(LDO, 6'd6, 6'd2, 24'hFF_FFF0), pfxWord(23'h00_0005), 3'b100,
			{6'd2, 12'd0}, 6'd6, 7'b1110001, octa, 64'h0000_0000_02FF_FFF0);
		addEntry("ldo_nopfx", memWord(LDO, 6'd6, 6'd2, 24'hFF_FFF0), 48'd0, 3'b100,
			{6'd2, 12'd0}, 6'd6, 7'b1110000, octa, 64'hFFFF_FFFF_FFFF_FFF0);
	endtask

	// ====================
	// Checks
	// ====================
	task automatic expectEqual(input string test, input string field, input logic [63:0] expVal,
			input logic [63:0] actVal);
		assert (actVal === expVal)
		else
		begin
			$display("ERROR %s %s: expected %0h, actual %0h", test, field, expVal, actVal);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	task automatic verifyEntry(input integer idx);
		string n;
		n = nameQ[idx];
		expectEqual(n, "decoValid", 64'(1'b1), 64'(decoValid));
		if (maskQ[idx][2])
			expectEqual(n, "decoRa", 64'(srcQ[idx][17:12]), 64'(decoRa));
		if (maskQ[idx][1])
			expectEqual(n, "decoRb", 64'(srcQ[idx][11:6]), 64'(decoRb));
		if (maskQ[idx][0])
			expectEqual(n, "decoRc", 64'(srcQ[idx][5:0]), 64'(decoRc));
		expectEqual(n, "decoRt", 64'(rtQ[idx]), 64'(decoRt));
		expectEqual(n, "decoRfwr", 64'(flagQ[idx][6]), 64'(decoRfwr));
		expectEqual(n, "decoMem", 64'(flagQ[idx][5]), 64'(decoMem));
		expectEqual(n, "decoMultiCycle", 64'(flagQ[idx][5]), 64'(decoMultiCycle));
		expectEqual(n, "decoLd", 64'(flagQ[idx][4]), 64'(decoLd));
		expectEqual(n, "decoSt", 64'(flagQ[idx][3]), 64'(decoSt));
		expectEqual(n, "decoMemsz", 64'(sizeQ[idx]), 64'(decoMemsz));
		expectEqual(n, "decoBranch", 64'(flagQ[idx][2]), 64'(decoBranch));
		expectEqual(n, "decoJmp", 64'(flagQ[idx][1]), 64'(decoJmp));
		expectEqual(n, "decoImm", immQ[idx], decoImm);
		expectEqual(n, "decoPostfixUsed", 64'(flagQ[idx][0]), 64'(decoPostfixUsed));
	endtask

	// Watchdog scaled to the table length
	initial
	begin
		#1;
		#((nameQ.size() + 20) * 20 - 1);
		$display("Timeout: the run did not finish within its time limit");
		$display("Checks failed");
		$fatal(1);
	end

	initial
	begin
		integer i;
		seed = 32'hb93f_17af;
		rst = 1'b1;
		irValid = 1'b0;
		ir = '0;
		xir = '0;
		buildTable();

		repeat (10) @(negedge clk);
		rst = 1'b0;
		expectEqual("reset", "decoValid", 64'd0, 64'(decoValid));
		expectEqual("reset", "decoImm", 64'd0, decoImm);

		// Entries run back to back with an idle cycle after every fourth one
		for (i = 0; i < nameQ.size(); i++)
		begin
			ir = irQ[i];
			xir = xirQ[i];
			irValid = 1'b1;
			@(negedge clk);
			verifyEntry(i);
			if (i % 4 == 3)
			begin
				// Idle cycle puts a NOP on the bus that the held fields must ignore
				irValid = 1'b0;
				ir = '0;
				xir = '0;
				@(negedge clk);
				expectEqual(nameQ[i], "decoValid after strobe", 64'd0, 64'(decoValid));
				expectEqual(nameQ[i], "decoImm held", immQ[i], decoImm);
			end
		end
		irValid = 1'b0;

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire
